/* spi_mem_cfg.svh */
/*
 * SPI byte memory configuration
 * sizes of the memory and the timing limit on the SPI master
 */
`ifndef SPI_MEM_CFG_SVH
`define SPI_MEM_CFG_SVH

// address bits in the command byte
// must not exceed SPI_DATA_W - 1, the r/w bit takes the LSB
`define SPI_ADDR_W 7

// one memory word, also the SPI frame width
`define SPI_DATA_W 8

// shortest sck half period in sclk cycles
// covers the synchronizer delay plus the read load path
`define SPI_MIN_HALF 8

`endif

/* source/spi_mem_pkg.sv */
/*
 * SPI byte memory shared types
 * controller states and the structs passed between blocks
 */
`default_nettype none

package spi_mem_pkg;

	// transaction states of spi_ctrl
	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_cmd        = 3'd1,
		st_write      = 3'd2,
		st_read_load  = 3'd3,
		st_read_shift = 3'd4,
		st_done       = 3'd5
	} spi_state_e;

	// synchronized pins and edge pulses
	typedef struct packed {
		// levels
		logic cs_n;
		logic mosi;
		// one-cycle pulses
		logic sck_rise;
		logic sck_fall;
		logic cs_fall;
	} pin_sync_t;

	// datapath controls from spi_ctrl
	typedef struct packed {
		// latch address from the shift register
		logic addr_we;
		// store the shift register byte
		logic mem_we;
		// parallel load of the read byte
		logic sr_load;
		// level, shift out on sck_fall
		logic shift_out;
		// level, miso output enable
		logic miso_en;
	} ctrl_cmd_t;

endpackage

`default_nettype wire

/* source/spi_mem_top.sv */
/*
 * SPI byte memory top level
 * connects synchronizer, shift register, storage and controller
 */
`timescale 1ns/1ps
`default_nettype none

module spi_mem_top import spi_mem_pkg::*; (
	input  logic sclk,
	input  logic arst_n,
	input  logic sck,
	input  logic cs_n,
	input  logic mosi,
	output logic miso,
	output logic miso_oe
);

	`include "spi_mem_cfg.svh"

	pin_sync_t              pins;
	ctrl_cmd_t              cmd;
	logic [`SPI_DATA_W-1:0] sr_data;
	logic [`SPI_DATA_W-1:0] rd_data;

	spi_input_sync i_sync (
		.sclk   (sclk),
		.arst_n (arst_n),
		.sck    (sck),
		.cs_n   (cs_n),
		.mosi   (mosi),
		.pins   (pins)
	);

	spi_shift_reg i_shift (
		.sclk      (sclk),
		.arst_n    (arst_n),
		.pins      (pins),
		.cmd       (cmd),
		.load_data (rd_data),
		.sr_data   (sr_data),
		.miso      (miso)
	);

	spi_data_mem i_mem (
		.sclk    (sclk),
		.arst_n  (arst_n),
		.cmd     (cmd),
		.sr_data (sr_data),
		.rd_data (rd_data)
	);

	spi_ctrl i_ctrl (
		.sclk    (sclk),
		.arst_n  (arst_n),
		.pins    (pins),
		.sr_data (sr_data),
		.cmd     (cmd)
	);

	// separate enable, the pad is outside
	assign miso_oe = cmd.miso_en;

endmodule

`default_nettype wire

/* source/spi_input_sync.sv */
/*
 * SPI pin synchronizer
 * brings cs_n, sck and mosi into the sclk domain and finds the edges
 */
`timescale 1ns/1ps
`default_nettype none

module spi_input_sync import spi_mem_pkg::*; (
	input  logic      sclk,
	input  logic      arst_n,
	input  logic      sck,
	input  logic      cs_n,
	input  logic      mosi,
	output pin_sync_t pins
);

	// stages 0 and 1 synchronize, stage 2 is the previous value
	logic [2:0] sck_q;
	logic [2:0] cs_q;
	logic [1:0] mosi_q;

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			sck_q  <= 3'b000;
			// chip select idles high
			cs_q   <= 3'b111;
			mosi_q <= 2'b00;
		end else begin
			sck_q  <= {sck_q[1:0], sck};
			cs_q   <= {cs_q[1:0], cs_n};
			mosi_q <= {mosi_q[0], mosi};
		end
	end

	// output register keeps levels and pulses aligned
	// a pin change shows up three cycles later
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			pins.cs_n     <= 1'b1;
			pins.mosi     <= 1'b0;
			pins.sck_rise <= 1'b0;
			pins.sck_fall <= 1'b0;
			pins.cs_fall  <= 1'b0;
		end else begin
			pins.cs_n     <= cs_q[1];
			pins.mosi     <= mosi_q[1];
			pins.sck_rise <= sck_q[1] & ~sck_q[2];
			pins.sck_fall <= ~sck_q[1] & sck_q[2];
			pins.cs_fall  <= ~cs_q[1] & cs_q[2];
		end
	end

endmodule

`default_nettype wire

/* source/spi_shift_reg.sv */
/*
 * SPI shift register
 * receives mosi bits and transmits the read byte on miso
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_mem_cfg.svh"

module spi_shift_reg import spi_mem_pkg::*; (
	input  logic                   sclk,
	input  logic                   arst_n,
	input  pin_sync_t              pins,
	input  ctrl_cmd_t              cmd,
	input  logic [`SPI_DATA_W-1:0] load_data,
	output logic [`SPI_DATA_W-1:0] sr_data,
	output logic                   miso
);

	logic [`SPI_DATA_W-1:0] sr_q;

	// one MSB-first register for both directions
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			sr_q <= '0;
		end else if (cmd.sr_load) begin
			sr_q <= load_data;
		end else if (cmd.shift_out) begin
			// transmit with zero fill from the bottom
			if (pins.sck_fall) begin
				sr_q <= {sr_q[`SPI_DATA_W-2:0], 1'b0};
			end
		end else if (pins.sck_rise && !pins.cs_n) begin
			// receive
			sr_q <= {sr_q[`SPI_DATA_W-2:0], pins.mosi};
		end
	end

	assign sr_data = sr_q;
	assign miso    = sr_q[`SPI_DATA_W-1];

endmodule

`default_nettype wire

/* source/spi_data_mem.sv */
/*
 * SPI byte memory storage
 * address latch and byte array with synchronous write and registered read
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_mem_cfg.svh"

module spi_data_mem import spi_mem_pkg::*; (
	input  logic                   sclk,
	input  logic                   arst_n,
	input  ctrl_cmd_t              cmd,
	input  logic [`SPI_DATA_W-1:0] sr_data,
	output logic [`SPI_DATA_W-1:0] rd_data
);

	localparam int DEPTH = 1 << `SPI_ADDR_W;

	logic [`SPI_ADDR_W-1:0] addr_q;
	logic [`SPI_DATA_W-1:0] mem [DEPTH];

	// command byte is address then r/w bit
	// the address sits right above bit 0
	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			addr_q <= '0;
		end else if (cmd.addr_we) begin
			addr_q <= sr_data[`SPI_ADDR_W:1];
		end
	end

	// read follows the latched address one cycle later
	always_ff @(posedge sclk) begin
		if (cmd.mem_we) begin
			mem[addr_q] <= sr_data;
		end
		rd_data <= mem[addr_q];
	end

endmodule

`default_nettype wire

/* source/spi_ctrl.sv */
/*
 * SPI transaction controller
 * tracks command, write and read phases and strobes the datapath
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_mem_cfg.svh"

module spi_ctrl import spi_mem_pkg::*; (
	input  logic                   sclk,
	input  logic                   arst_n,
	input  pin_sync_t              pins,
	input  logic [`SPI_DATA_W-1:0] sr_data,
	output ctrl_cmd_t              cmd
);

	localparam logic [3:0] LAST_BIT = 4'(`SPI_DATA_W - 1);

	spi_state_e state;
	// shared by all phases and cleared on every phase change
	logic [3:0] bit_cnt;

	always_ff @(posedge sclk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_idle;
			bit_cnt <= '0;
			cmd     <= '0;
		end else begin
			// strobes last one cycle
			cmd.addr_we <= 1'b0;
			cmd.mem_we  <= 1'b0;
			cmd.sr_load <= 1'b0;

			if (pins.cs_n && state != st_idle) begin
				// abort or normal end with nothing stored
				state         <= st_idle;
				bit_cnt       <= '0;
				cmd.shift_out <= 1'b0;
				cmd.miso_en   <= 1'b0;
			end else begin
				case (state)
					st_idle: begin
						if (pins.cs_fall) begin
							state   <= st_cmd;
							bit_cnt <= '0;
						end
					end

					st_cmd: begin
						if (cmd.addr_we) begin
							// command byte complete and its LSB is r/w
							bit_cnt <= '0;
							state   <= sr_data[0] ? st_read_load : st_write;
						end else if (pins.sck_rise) begin
							if (bit_cnt == LAST_BIT) begin
								cmd.addr_we <= 1'b1;
								bit_cnt     <= '0;
							end else begin
								bit_cnt <= bit_cnt + 4'd1;
							end
						end
					end

					st_write: begin
						if (pins.sck_rise) begin
							if (bit_cnt == LAST_BIT) begin
								// data byte is in the shift register now
								cmd.mem_we <= 1'b1;
								bit_cnt    <= '0;
								state      <= st_done;
							end else begin
								bit_cnt <= bit_cnt + 4'd1;
							end
						end
					end

					st_read_load: begin
						// first cycle waits for rd_data
						if (cmd.sr_load) begin
							state       <= st_read_shift;
							cmd.miso_en <= 1'b1;
						end else begin
							cmd.sr_load <= 1'b1;
						end
					end

					st_read_shift: begin
						// the first fall closes the command byte
						// and must not shift the MSB away
						if (pins.sck_fall) begin
							if (bit_cnt == LAST_BIT) begin
								cmd.shift_out <= 1'b0;
								bit_cnt       <= '0;
								state         <= st_done;
							end else begin
								cmd.shift_out <= 1'b1;
								bit_cnt       <= bit_cnt + 4'd1;
							end
						end
					end

					st_done: begin
						// wait for cs_n high in the branch above
						state <= st_done;
					end

					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/spi_mem_chk.sv */
/*
 * SPI controller checker
 * protocol rules on the strobes and states of spi_ctrl
 */
`timescale 1ns/1ps
`default_nettype none

module spi_mem_chk import spi_mem_pkg::*; (
	input logic       sclk,
	input logic       arst_n,
	input spi_state_e state,
	input ctrl_cmd_t  cmd
);

	// a memory write and a read load never share a cycle
	write_load_excl: assert property (
		@(posedge sclk) disable iff (!arst_n)
		!(cmd.mem_we && cmd.sr_load)
	) else $error("mem_we and sr_load are high in the same cycle");

	// output enable only inside a transaction
	idle_no_oe: assert property (
		@(posedge sclk) disable iff (!arst_n)
		(state == st_idle) |-> !cmd.miso_en
	) else $error("miso_en is high while the controller is idle");

	// address latch strobe lasts one cycle
	addr_we_pulse: assert property (
		@(posedge sclk) disable iff (!arst_n)
		cmd.addr_we |=> !cmd.addr_we
	) else $error("addr_we stayed high for more than one cycle");

endmodule

`default_nettype wire

/* testbench/spi_mem_tb.sv */
/*
 * SPI byte memory testbench
 * SPI master tasks and directed tests against a reference byte array
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_mem_cfg.svh"

module spi_mem_tb;

	localparam int HALF      = `SPI_MIN_HALF;
	localparam int DEPTH     = 1 << `SPI_ADDR_W;
	localparam int NUM_TRANS = 23;
	// command and data byte at a full sck period per bit plus framing
	localparam int TRANS_CYCLES = 2 * `SPI_DATA_W * 2 * HALF + 4 * HALF;
	localparam int CYCLE_LIMIT  = NUM_TRANS * TRANS_CYCLES + 200;

	logic sclk;
	logic arst_n;
	logic sck;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;

	// set while miso_oe has to stay low
	logic oe_low_chk;
	int   cycle_cnt = 0;

	// expected memory contents
	logic [`SPI_DATA_W-1:0] model [DEPTH];

	spi_mem_top i_dut (
		.sclk    (sclk),
		.arst_n  (arst_n),
		.sck     (sck),
		.cs_n    (cs_n),
		.mosi    (mosi),
		.miso    (miso),
		.miso_oe (miso_oe)
	);

	bind spi_ctrl spi_mem_chk i_chk (
		.sclk   (sclk),
		.arst_n (arst_n),
		.state  (state),
		.cmd    (cmd)
	);

	initial begin
		sclk = 1'b0;
		forever #2 sclk = ~sclk;
	end

	always @(posedge sclk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d sclk cycles, the tests did not finish",
				cycle_cnt);
			$display("Something failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		if (got !== exp) begin
			$display("Mismatch %s exp 0x%0h got 0x%0h", name, exp, got);
			$display("Something failed");
			$fatal(1, "check of %s failed", name);
		end
	endtask

	always @(posedge sclk) begin
		if (oe_low_chk) begin
			check_val("miso_oe", 32'h0, 32'(miso_oe));
		end
	end

	// every call ends 1 ns after a rising sclk edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge sclk);
		end
		#1;
	endtask

	function automatic logic [`SPI_ADDR_W-1:0] to_addr(input int a);
		logic [31:0] v;
		v = a;
		return v[`SPI_ADDR_W-1:0];
	endfunction

	// address above the r/w bit
	function automatic logic [`SPI_DATA_W-1:0] make_cmd(
			input logic [`SPI_ADDR_W-1:0] addr, input logic rd);
		logic [`SPI_DATA_W-1:0] c;
		c = '0;
		c[`SPI_ADDR_W:0] = {addr, rd};
		return c;
	endfunction

	// mode 0 with mosi set after the falling edge
	task automatic send_bit(input logic b);
		mosi = b;
		wait_cycles(HALF);
		sck = 1'b1;
		wait_cycles(HALF);
		sck = 1'b0;
	endtask

	task automatic recv_bit(output logic b);
		wait_cycles(HALF);
		check_val("miso_oe", 32'h1, 32'(miso_oe));
		b = miso;
		sck = 1'b1;
		wait_cycles(HALF);
		sck = 1'b0;
	endtask

	task automatic end_frame();
		wait_cycles(HALF);
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_cycles(2 * HALF);
	endtask

	// nbits below a full byte aborts the write
	task automatic write_bits(input logic [`SPI_ADDR_W-1:0] addr,
			input logic [`SPI_DATA_W-1:0] data, input int nbits);
		logic [`SPI_DATA_W-1:0] c;
		int i;
		c = make_cmd(addr, 1'b0);
		oe_low_chk = 1'b1;
		cs_n = 1'b0;
		wait_cycles(HALF);
		for (i = `SPI_DATA_W - 1; i >= 0; i--) begin
			send_bit(c[i]);
		end
		for (i = 0; i < nbits; i++) begin
			send_bit(data[`SPI_DATA_W-1-i]);
		end
		end_frame();
		oe_low_chk = 1'b0;
	endtask

	task automatic spi_write(input logic [`SPI_ADDR_W-1:0] addr,
			input logic [`SPI_DATA_W-1:0] data);
		write_bits(addr, data, `SPI_DATA_W);
		model[addr] = data;
	endtask

	task automatic spi_read(input logic [`SPI_ADDR_W-1:0] addr,
			output logic [`SPI_DATA_W-1:0] data);
		logic [`SPI_DATA_W-1:0] c;
		logic b;
		int i;
		c = make_cmd(addr, 1'b1);
		oe_low_chk = 1'b1;
		cs_n = 1'b0;
		wait_cycles(HALF);
		for (i = `SPI_DATA_W - 1; i >= 1; i--) begin
			send_bit(c[i]);
		end
		// enable may rise once the last command bit is clocked in
		oe_low_chk = 1'b0;
		send_bit(c[0]);
		for (i = `SPI_DATA_W - 1; i >= 0; i--) begin
			recv_bit(b);
			data[i] = b;
		end
		end_frame();
		check_val("miso_oe", 32'h0, 32'(miso_oe));
	endtask

	task automatic read_check(input logic [`SPI_ADDR_W-1:0] addr);
		logic [`SPI_DATA_W-1:0] got;
		spi_read(addr, got);
		check_val("miso byte", 32'(model[addr]), 32'(got));
	endtask

	task automatic reset_values();
		check_val("miso", 32'h0, 32'(miso));
		check_val("miso_oe", 32'h0, 32'(miso_oe));
	endtask

	task automatic write_then_read();
		spi_write(to_addr(45), 8'hc5);
		read_check(to_addr(45));
	endtask

	// distinct random addresses read back in reverse order
	task automatic distinct_addresses();
		logic [`SPI_ADDR_W-1:0] addrs [8];
		bit taken [DEPTH];
		logic [31:0] r;
		int n;
		n = 0;
		while (n < 8) begin
			r = $urandom;
			if (!taken[r[`SPI_ADDR_W-1:0]]) begin
				taken[r[`SPI_ADDR_W-1:0]] = 1'b1;
				addrs[n] = r[`SPI_ADDR_W-1:0];
				n++;
			end
		end
		for (n = 0; n < 8; n++) begin
			r = $urandom;
			spi_write(addrs[n], r[`SPI_DATA_W-1:0]);
		end
		for (n = 7; n >= 0; n--) begin
			read_check(addrs[n]);
		end
	endtask

	task automatic abort_keeps_byte();
		spi_write(to_addr(65), 8'h3c);
		write_bits(to_addr(65), 8'ha5, 4);
		read_check(to_addr(65));
	endtask

	// write runs under the monitor and read checks the enable per bit
	task automatic oe_window();
		spi_write(to_addr(126), 8'h81);
		check_val("miso_oe", 32'h0, 32'(miso_oe));
		read_check(to_addr(126));
	endtask

	initial begin
		arst_n     = 1'b0;
		sck        = 1'b0;
		cs_n       = 1'b1;
		mosi       = 1'b0;
		oe_low_chk = 1'b0;
		void'($urandom(32'hc9963d7e));
		wait_cycles(3);
		arst_n = 1'b1;
		wait_cycles(2);

		reset_values();
		write_then_read();
		distinct_addresses();
		abort_keeps_byte();
		oe_window();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
source/spi_mem_pkg.sv
source/spi_mem_top.sv
source/spi_input_sync.sv
source/spi_shift_reg.sv
source/spi_data_mem.sv
source/spi_ctrl.sv
testbench/spi_mem_chk.sv
testbench/spi_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = spi_mem_tb
FLIST     = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
